//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Address geometry
    localparam int PAGE_BITS      = 12;
    localparam int VPPN_BITS      = 32 - PAGE_BITS;
    localparam int TLB_ENTRIES    = 4;
    localparam int TLB_IDX_BITS   = $clog2(TLB_ENTRIES);
    localparam int LINE_BYTES     = 16;
    localparam int NSET           = 64;
    localparam int LINE_INDEX_LSB = $clog2(LINE_BYTES);
    localparam int LINE_INDEX_MSB = LINE_INDEX_LSB + $clog2(NSET) - 1;
    localparam int RAM_WORDS      = 256;
    localparam int RAM_IDX_BITS   = $clog2(RAM_WORDS);

    typedef struct packed {
        logic [VPPN_BITS-1:0] vppn;
        logic [VPPN_BITS-1:0] ppn;
        logic                 v;
        logic                 d;
        logic [1:0]           plv;
        logic [1:0]           mat;
        logic                 e;
    } tlb_entry_t;

    typedef struct packed {
        logic                 found;
        logic [VPPN_BITS-1:0] ppn;
        logic                 v;
        logic                 d;
        logic [1:0]           plv;
    } tlb_result_t;

    typedef struct packed {
        logic adem;
        logic tlbr;
        logic pil;
        logic pis;
        logic ppi;
        logic pme;
    } excp_flags_t;

    // Word-aligned address, lanes picked by sel
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [31:0] addr;
        logic [3:0]  sel;
        logic [31:0] data;
    } ram_req_t;

endpackage

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

    import mem_pkg::*;

    typedef enum logic [3:0] {
        NOP,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W,
        ST_B,
        ST_H,
        ST_W,
        LL,
        SC
    } mem_op_e;

    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [31:0] mem_addr;
        logic [31:0] store_data;
        logic [4:0]  waddr;
        logic        trans_en;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [31:0] mem_addr;
        logic [4:0]  waddr;
        logic        wreg;
        logic [31:0] wdata;
        excp_flags_t excp;
        logic        ll_we;
        logic        ll_value;
    } mem1_mem2_t;

    typedef struct packed {
        logic        valid;
        logic        wreg;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        excp_flags_t excp;
    } wb_t;

endpackage

`default_nettype wire

//--- logic/tlb_lookup.sv
`default_nettype none

module tlb_lookup
    import mem_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,

    input  wire                    fill_we_i,
    input  wire [TLB_IDX_BITS-1:0] fill_idx_i,
    input  wire tlb_entry_t        fill_entry_i,

    input  wire [VPPN_BITS-1:0]    vppn_i,
    output tlb_result_t            result_o
);

    tlb_entry_t             entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (fill_we_i) begin
            entries[fill_idx_i] <= fill_entry_i;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit[i] = entries[i].e && (entries[i].vppn == vppn_i);
        end
    end

    // Scan downwards so the lowest matching entry wins
    always_comb begin
        result_o = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                result_o.found = 1'b1;
                result_o.ppn   = entries[i].ppn;
                result_o.v     = entries[i].v;
                result_o.d     = entries[i].d;
                result_o.plv   = entries[i].plv;
            end
        end
    end

    // Fill software must keep pages unique
    a_unique_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
        else $error("tlb_lookup: several entries match vppn %h", vppn_i);

endmodule

`default_nettype wire

//--- logic/mem1_stage.sv
`default_nettype none

module mem1_stage
    import core_pkg::*;
    import mem_pkg::*;
(
    input  wire              clk,
    input  wire              rst,

    input  wire              flush_i,
    input  wire              advance_i,
    output logic             advance_ready_o,

    input  wire ex_mem_t     ex_i,
    input  wire [1:0]        csr_plv_i,
    input  wire tlb_result_t tlb_i,
    input  wire              ll_bit_i,

    input  wire              ram_ready_i,
    output ram_req_t         ram_req_o,

    output mem1_mem2_t       mem2_o
);

    logic [31:0]                          paddr;
    logic [1:0]                           off;
    logic                                 is_load;
    logic                                 is_store;
    logic                                 store_op;
    logic                                 access_mem;
    logic                                 accept;
    excp_flags_t                          excp;
    logic                                 excp_any;
    logic [LINE_INDEX_MSB:LINE_INDEX_LSB] line_idx;
    logic [LINE_INDEX_MSB:LINE_INDEX_LSB] hist0_idx;
    logic [LINE_INDEX_MSB:LINE_INDEX_LSB] hist1_idx;
    logic                                 hist0_vld;
    logic                                 hist1_vld;
    logic                                 same_line;
    mem1_mem2_t                           mem2_d;

    assign paddr = ex_i.trans_en ? {tlb_i.ppn, ex_i.mem_addr[PAGE_BITS-1:0]} : ex_i.mem_addr;
    assign off   = paddr[1:0];

    assign is_load    = ex_i.op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL};
    assign is_store   = ex_i.op inside {ST_B, ST_H, ST_W, SC};
    assign access_mem = ex_i.valid && (is_load || is_store);
    // A failing SC never writes memory
    assign store_op   = is_store && !(ex_i.op == SC && !ll_bit_i);

    assign excp.adem = access_mem && ex_i.trans_en && (csr_plv_i == 2'd3) && ex_i.mem_addr[31];
    assign excp.tlbr = access_mem && ex_i.trans_en && !tlb_i.found;
    assign excp.pil  = access_mem && ex_i.trans_en && tlb_i.found && is_load && !tlb_i.v;
    assign excp.pis  = access_mem && ex_i.trans_en && tlb_i.found && store_op && !tlb_i.v;
    assign excp.ppi  = access_mem && ex_i.trans_en && tlb_i.found && tlb_i.v &&
                       (csr_plv_i > tlb_i.plv);
    assign excp.pme  = access_mem && ex_i.trans_en && tlb_i.found && tlb_i.v && store_op &&
                       (csr_plv_i <= tlb_i.plv) && !tlb_i.d;
    assign excp_any  = |excp;

    // Same-line check against the two most recent accesses
    assign line_idx  = paddr[LINE_INDEX_MSB:LINE_INDEX_LSB];
    assign same_line = (hist0_vld && hist0_idx == line_idx) ||
                       (hist1_vld && hist1_idx == line_idx);

    assign advance_ready_o = access_mem ? (ram_ready_i && !same_line) : 1'b1;
    assign accept          = advance_i && advance_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            hist0_vld <= 1'b0;
            hist1_vld <= 1'b0;
        end else begin
            hist0_vld <= accept && access_mem;
            hist1_vld <= hist0_vld;
        end
    end

    always_ff @(posedge clk) begin
        hist0_idx <= line_idx;
        hist1_idx <= hist0_idx;
    end

    always_comb begin
        ram_req_o = '0;
        if (accept && access_mem && !excp_any && (is_load || store_op)) begin
            ram_req_o.valid = 1'b1;
            ram_req_o.we    = store_op;
            ram_req_o.addr  = {paddr[31:2], 2'b00};
            case (ex_i.op)
                LD_B, LD_BU, ST_B: begin
                    ram_req_o.sel  = 4'b0001 << off;
                    ram_req_o.data = {24'b0, ex_i.store_data[7:0]} << {off, 3'b000};
                end
                LD_H, LD_HU, ST_H: begin
                    ram_req_o.sel  = 4'b0011 << off;
                    ram_req_o.data = {16'b0, ex_i.store_data[15:0]} << {off, 3'b000};
                end
                default: begin
                    ram_req_o.sel  = 4'b1111;
                    ram_req_o.data = ex_i.store_data;
                end
            endcase
        end
    end

    always_comb begin
        mem2_d          = '0;
        mem2_d.valid    = ex_i.valid;
        mem2_d.op       = ex_i.op;
        mem2_d.mem_addr = ex_i.mem_addr;
        mem2_d.waddr    = ex_i.waddr;
        mem2_d.excp     = excp;
        if (access_mem && !excp_any) begin
            mem2_d.wreg = is_load || ex_i.op == SC;
            case (ex_i.op)
                LL: begin
                    mem2_d.ll_we    = 1'b1;
                    mem2_d.ll_value = 1'b1;
                end
                SC: begin
                    mem2_d.ll_we = 1'b1;
                    mem2_d.wdata = {31'b0, ll_bit_i};
                end
                default: begin
                end
            endcase
        end
    end

    // Nothing downstream stalls, so an idle cycle loads a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            mem2_o <= '0;
        end else begin
            mem2_o <= accept ? mem2_d : '0;
        end
    end

    // The RAM is busy for the cycle after a write
    a_no_req_after_write: assert property (@(posedge clk) disable iff (rst)
        (ram_req_o.valid && ram_req_o.we) |=> !ram_req_o.valid)
        else $error("mem1_stage: RAM request issued in the busy cycle after a write");

endmodule

`default_nettype wire

//--- logic/mem2_stage.sv
`default_nettype none

module mem2_stage
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rst,

    input  wire             flush_i,
    input  wire mem1_mem2_t mem1_i,
    input  wire [31:0]      rdata_i,

    output logic            ll_bit_o,
    output wb_t             wb_o
);

    logic [31:0] shifted;
    logic [31:0] load_data;
    wb_t         wb_d;

    // Move the addressed lane down to bit 0
    assign shifted = rdata_i >> {mem1_i.mem_addr[1:0], 3'b000};

    always_comb begin
        case (mem1_i.op)
            LD_B:      load_data = {{24{shifted[7]}}, shifted[7:0]};
            LD_BU:     load_data = {24'b0, shifted[7:0]};
            LD_H:      load_data = {{16{shifted[15]}}, shifted[15:0]};
            LD_HU:     load_data = {16'b0, shifted[15:0]};
            LD_W, LL:  load_data = rdata_i;
            default:   load_data = mem1_i.wdata;
        endcase
    end

    always_comb begin
        wb_d.valid = mem1_i.valid;
        wb_d.wreg  = mem1_i.wreg;
        wb_d.waddr = mem1_i.waddr;
        wb_d.wdata = load_data;
        wb_d.excp  = mem1_i.excp;
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            ll_bit_o <= 1'b0;
        end else if (mem1_i.valid && !(|mem1_i.excp) && mem1_i.ll_we) begin
            ll_bit_o <= mem1_i.ll_value;
        end
    end

    a_no_wreg_on_excp: assert property (@(posedge clk) disable iff (rst)
        (mem1_i.valid && |mem1_i.excp) |-> !mem1_i.wreg)
        else $error("mem2_stage: faulting record writes a register");

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`default_nettype none

module data_ram
    import mem_pkg::*;
(
    input  wire           clk,
    input  wire           rst,

    input  wire ram_req_t req_i,
    output logic          ready_o,
    output logic [31:0]   rdata_o
);

    logic [31:0]             mem [RAM_WORDS];
    logic [RAM_IDX_BITS-1:0] idx;
    logic                    busy;

    // Upper address bits alias onto the same words
    assign idx = req_i.addr[RAM_IDX_BITS+1:2];

    always_ff @(posedge clk) begin
        if (req_i.valid && req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.sel[b]) begin
                    mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.valid && !req_i.we) begin
            rdata_o <= mem[idx];
        end
    end

    // One dead cycle after every write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= req_i.valid && req_i.we;
        end
    end

    assign ready_o = !busy;

endmodule

`default_nettype wire

//--- logic/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top
    import core_pkg::*;
    import mem_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,

    input  wire ex_mem_t           ex_i,
    input  wire                    advance_i,
    output logic                   advance_ready_o,
    input  wire                    flush_i,
    input  wire [1:0]              csr_plv_i,

    input  wire tlb_entry_t        tlb_fill_i,
    input  wire [TLB_IDX_BITS-1:0] tlb_fill_idx_i,
    input  wire                    tlb_fill_we_i,

    output wb_t                    wb_o
);

    tlb_result_t tlb_result;
    ram_req_t    ram_req;
    logic        ram_ready;
    logic [31:0] ram_rdata;
    mem1_mem2_t  mem1_mem2;
    logic        ll_bit;

    tlb_lookup u_tlb_lookup (
        .clk          (clk),
        .rst          (rst),
        .fill_we_i    (tlb_fill_we_i),
        .fill_idx_i   (tlb_fill_idx_i),
        .fill_entry_i (tlb_fill_i),
        .vppn_i       (ex_i.mem_addr[31:PAGE_BITS]),
        .result_o     (tlb_result)
    );

    mem1_stage u_mem1_stage (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .advance_i       (advance_i),
        .advance_ready_o (advance_ready_o),
        .ex_i            (ex_i),
        .csr_plv_i       (csr_plv_i),
        .tlb_i           (tlb_result),
        .ll_bit_i        (ll_bit),
        .ram_ready_i     (ram_ready),
        .ram_req_o       (ram_req),
        .mem2_o          (mem1_mem2)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .rst     (rst),
        .req_i   (ram_req),
        .ready_o (ram_ready),
        .rdata_o (ram_rdata)
    );

    mem2_stage u_mem2_stage (
        .clk      (clk),
        .rst      (rst),
        .flush_i  (flush_i),
        .mem1_i   (mem1_mem2),
        .rdata_i  (ram_rdata),
        .ll_bit_o (ll_bit),
        .wb_o     (wb_o)
    );

endmodule

`default_nettype wire

//--- test/tb_mem_subsys.sv
`default_nettype none

module tb_mem_subsys
    import core_pkg::*;
    import mem_pkg::*;
();

    localparam int N_ROWS    = 42;
    localparam int RAND_INIT = 16;
    localparam int RAND_OPS  = 200;
    localparam int LIMIT     = 40 * (N_ROWS + RAND_INIT + RAND_OPS) + 40;

    localparam excp_flags_t E_NONE = excp_flags_t'(6'b000000);
    localparam excp_flags_t E_ADEM = excp_flags_t'(6'b110000);
    localparam excp_flags_t E_TLBR = excp_flags_t'(6'b010000);
    localparam excp_flags_t E_PIL  = excp_flags_t'(6'b001000);
    localparam excp_flags_t E_PIS  = excp_flags_t'(6'b000100);
    localparam excp_flags_t E_PPI  = excp_flags_t'(6'b000010);
    localparam excp_flags_t E_PME  = excp_flags_t'(6'b000001);

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] vaddr;
        logic [31:0] sdata;
        logic        trans;
        logic [1:0]  plv;
        logic [31:0] wdata;
        excp_flags_t excp;
        logic        stall;
    } row_t;

    typedef struct packed {
        logic [15:0] id;
        logic        wreg;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        excp_flags_t excp;
    } exp_t;

    logic                    clk = 1'b0;
    logic                    rst;
    ex_mem_t                 ex;
    logic                    advance;
    logic                    advance_ready;
    logic                    flush;
    logic [1:0]              plv;
    tlb_entry_t              fill;
    logic [TLB_IDX_BITS-1:0] fill_idx;
    logic                    fill_we;
    wb_t                     wb;

    exp_t       exp_q [$];
    exp_t       got_exp;
    logic [7:0] model [1024];
    integer     seed;
    int         errors = 0;
    int         checked = 0;
    int         rand_loads = 0;
    int         cycles = 0;
    int         issued = 0;

    // User page, invalid page, clean alias of the user page, kernel page
    tlb_entry_t pages [TLB_ENTRIES] = '{
        '{20'h00010, 20'h00055, 1'b1, 1'b1, 2'd3, 2'd1, 1'b1},
        '{20'h00020, 20'h00066, 1'b0, 1'b1, 2'd3, 2'd1, 1'b1},
        '{20'h00030, 20'h00055, 1'b1, 1'b0, 2'd3, 2'd1, 1'b1},
        '{20'h00040, 20'h00077, 1'b1, 1'b1, 2'd0, 2'd1, 1'b1}
    };

    // op, vaddr, store data, trans_en, plv, expected wdata, expected flags, stall seen
    row_t rows [N_ROWS] = '{
        '{ST_B,  32'h0000_0004, 32'h1234_5681, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{ST_B,  32'h0000_0005, 32'hAAAA_AA02, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{ST_B,  32'h0000_0006, 32'h5555_5583, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{ST_B,  32'h0000_0007, 32'h0000_0004, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{ST_H,  32'h0000_0008, 32'hABCD_8001, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{ST_H,  32'h0000_000A, 32'h1234_7FFE, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{ST_W,  32'h0000_000C, 32'hDEAD_BEEF, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{LD_B,  32'h0000_0004, 32'h0, 1'b0, 2'd0, 32'hFFFF_FF81, E_NONE, 1'b0},
        '{LD_BU, 32'h0000_0005, 32'h0, 1'b0, 2'd0, 32'h0000_0002, E_NONE, 1'b0},
        '{LD_BU, 32'h0000_0006, 32'h0, 1'b0, 2'd0, 32'h0000_0083, E_NONE, 1'b0},
        '{LD_B,  32'h0000_0007, 32'h0, 1'b0, 2'd0, 32'h0000_0004, E_NONE, 1'b0},
        '{LD_H,  32'h0000_0008, 32'h0, 1'b0, 2'd0, 32'hFFFF_8001, E_NONE, 1'b0},
        '{LD_HU, 32'h0000_000A, 32'h0, 1'b0, 2'd0, 32'h0000_7FFE, E_NONE, 1'b0},
        '{LD_H,  32'h0000_000E, 32'h0, 1'b0, 2'd0, 32'hFFFF_DEAD, E_NONE, 1'b0},
        '{LD_W,  32'h0000_000C, 32'h0, 1'b0, 2'd0, 32'hDEAD_BEEF, E_NONE, 1'b0},
        '{LD_W,  32'h0000_0004, 32'h0, 1'b0, 2'd0, 32'h0483_0281, E_NONE, 1'b0},
        '{ST_W,  32'h0001_0040, 32'hCAFE_F00D, 1'b1, 2'd3, 32'h0, E_NONE, 1'b0},
        '{LD_W,  32'h0005_5040, 32'h0, 1'b0, 2'd0, 32'hCAFE_F00D, E_NONE, 1'b0},
        '{LD_HU, 32'h0003_0042, 32'h0, 1'b1, 2'd3, 32'h0000_CAFE, E_NONE, 1'b0},
        '{ST_W,  32'h0005_0040, 32'h1111_1111, 1'b1, 2'd3, 32'h0, E_TLBR, 1'b0},
        '{ST_W,  32'h0002_0040, 32'h2222_2222, 1'b1, 2'd3, 32'h0, E_PIS, 1'b0},
        '{LD_W,  32'h0002_0040, 32'h0, 1'b1, 2'd3, 32'h0, E_PIL, 1'b0},
        '{LD_W,  32'h0004_0040, 32'h0, 1'b1, 2'd3, 32'h0, E_PPI, 1'b0},
        '{ST_W,  32'h0003_0040, 32'h3333_3333, 1'b1, 2'd3, 32'h0, E_PME, 1'b0},
        '{ST_W,  32'h8001_0040, 32'h4444_4444, 1'b1, 2'd3, 32'h0, E_ADEM, 1'b0},
        '{LD_W,  32'h0000_0040, 32'h0, 1'b0, 2'd0, 32'hCAFE_F00D, E_NONE, 1'b0},
        '{ST_W,  32'h0000_0080, 32'h0000_AAAA, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{SC,    32'h0000_0080, 32'h0000_5555, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{LL,    32'h0000_0080, 32'h0, 1'b0, 2'd0, 32'h0000_AAAA, E_NONE, 1'b0},
        '{SC,    32'h0000_0080, 32'h1234_5678, 1'b0, 2'd0, 32'h1, E_NONE, 1'b0},
        '{SC,    32'h0000_0080, 32'h9999_9999, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{LL,    32'h0000_0080, 32'h0, 1'b0, 2'd0, 32'h1234_5678, E_NONE, 1'b0},
        '{NOP,   32'h0, 32'h0, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{SC,    32'h0000_0080, 32'h7777_7777, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{LD_W,  32'h0000_0080, 32'h0, 1'b0, 2'd0, 32'h1234_5678, E_NONE, 1'b0},
        '{ST_W,  32'h0000_00C0, 32'h0101_0101, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{ST_W,  32'h0000_00C4, 32'h0202_0202, 1'b0, 2'd0, 32'h0, E_NONE, 1'b1},
        '{LD_W,  32'h0000_00C4, 32'h0, 1'b0, 2'd0, 32'h0202_0202, E_NONE, 1'b0},
        '{LD_W,  32'h0000_00C0, 32'h0, 1'b0, 2'd0, 32'h0101_0101, E_NONE, 1'b0},
        '{ST_W,  32'h0000_0100, 32'h0A0A_0A0A, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{ST_W,  32'h0000_0140, 32'h0B0B_0B0B, 1'b0, 2'd0, 32'h0, E_NONE, 1'b0},
        '{LD_W,  32'h0000_0100, 32'h0, 1'b0, 2'd0, 32'h0A0A_0A0A, E_NONE, 1'b0}
    };

    mem_subsys_top u_mem_subsys_top (
        .clk             (clk),
        .rst             (rst),
        .ex_i            (ex),
        .advance_i       (advance),
        .advance_ready_o (advance_ready),
        .flush_i         (flush),
        .csr_plv_i       (plv),
        .tlb_fill_i      (fill),
        .tlb_fill_idx_i  (fill_idx),
        .tlb_fill_we_i   (fill_we),
        .wb_o            (wb)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the run went past %0d cycles", LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // Bytes addressed by the RAM word index and lane
    function automatic logic [31:0] model_load(input mem_op_e op, input logic [9:0] a);
        logic [31:0] w;
        logic [31:0] s;
        w = {model[{a[9:2], 2'd3}], model[{a[9:2], 2'd2}],
             model[{a[9:2], 2'd1}], model[{a[9:2], 2'd0}]};
        s = w >> {a[1:0], 3'b000};
        case (op)
            LD_B:    model_load = {{24{s[7]}}, s[7:0]};
            LD_BU:   model_load = {24'd0, s[7:0]};
            LD_H:    model_load = {{16{s[15]}}, s[15:0]};
            LD_HU:   model_load = {16'd0, s[15:0]};
            default: model_load = w;
        endcase
    endfunction

    task automatic model_store(input mem_op_e op, input logic [9:0] a, input logic [31:0] d);
        case (op)
            ST_B: model[a] = d[7:0];
            ST_H: begin
                model[a] = d[7:0];
                model[a + 10'd1] = d[15:8];
            end
            default: begin
                for (int b = 0; b < 4; b++) begin
                    model[{a[9:2], 2'(b)}] = d[8*b +: 8];
                end
            end
        endcase
    endtask

    // Hold the record until accepted, then queue what wb_o must show
    task automatic run_op(input logic [15:0] id, input mem_op_e op, input logic [31:0] vaddr,
                          input logic [31:0] sdata, input logic trans, input logic [1:0] p,
                          input logic [31:0] wdata, input excp_flags_t excp,
                          output int stalls);
        exp_t e;
        logic ok;
        e.id    = id;
        e.waddr = 5'(issued);
        e.wdata = wdata;
        e.excp  = excp;
        e.wreg  = (excp == E_NONE) && (op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL, SC});
        issued++;
        if (excp == E_NONE && (op inside {ST_B, ST_H, ST_W} || (op == SC && wdata == 32'd1))) begin
            model_store(op, vaddr[9:0], sdata);
        end
        ex      = '{1'b1, op, vaddr, sdata, e.waddr, trans};
        plv     = p;
        advance = 1'b1;
        stalls  = 0;
        ok      = 1'b0;
        while (!ok) begin
            #2;
            ok = advance_ready;
            if (!ok) begin
                stalls++;
            end
            @(posedge clk);
            #1;
        end
        exp_q.push_back(e);
        advance  = 1'b0;
        ex.valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic flush_link(input int id);
        drain();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        $display("row %0d flush issued", id);
    endtask

    // wb_o is stable at the falling edge
    always @(negedge clk) begin
        if (!rst && wb.valid) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: writeback arrived with nothing outstanding", $time);
                errors++;
            end else begin
                got_exp = exp_q.pop_front();
                checked++;
                if (wb.wreg !== got_exp.wreg || wb.excp !== got_exp.excp ||
                    wb.waddr !== got_exp.waddr ||
                    (got_exp.wreg && wb.wdata !== got_exp.wdata)) begin
                    $display("FAIL t=%0t id %0d: wb %b %0d %b %h, expected %b %0d %b %h",
                             $time, got_exp.id, wb.wreg, wb.waddr, wb.excp, wb.wdata,
                             got_exp.wreg, got_exp.waddr, got_exp.excp, got_exp.wdata);
                    errors++;
                end else if (got_exp.id != 16'hFFFF) begin
                    $display("row %0d ok", got_exp.id);
                end
                if (got_exp.id == 16'hFFFF && got_exp.wreg) begin
                    rand_loads++;
                end
            end
        end
    end

    initial begin
        int          stalls;
        logic [31:0] r;
        logic [31:0] addr;
        mem_op_e     op;
        seed     = 22122;
        rst      = 1'b1;
        ex       = '0;
        advance  = 1'b0;
        flush    = 1'b0;
        plv      = 2'd0;
        fill     = '0;
        fill_idx = '0;
        fill_we  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        if (!advance_ready || wb.valid) begin
            $display("FAIL t=%0t state after reset: ready %b wb valid %b",
                     $time, advance_ready, wb.valid);
            errors++;
        end

        for (int i = 0; i < TLB_ENTRIES; i++) begin
            fill_we  = 1'b1;
            fill_idx = TLB_IDX_BITS'(i);
            fill     = pages[i];
            @(posedge clk);
            #1;
        end
        fill_we = 1'b0;

        for (int i = 0; i < N_ROWS; i++) begin
            if (rows[i].op == NOP) begin
                flush_link(i);
            end else begin
                run_op(16'(i), rows[i].op, rows[i].vaddr, rows[i].sdata, rows[i].trans,
                       rows[i].plv, rows[i].wdata, rows[i].excp, stalls);
                if (rows[i].stall && stalls == 0) begin
                    $display("FAIL t=%0t row %0d: advance_ready_o never went low", $time, i);
                    errors++;
                end
            end
        end

        // Random region is 16 words at 0x300, written first
        for (int i = 0; i < RAND_INIT; i++) begin
            r = $random(seed);
            run_op(16'hFFFF, ST_W, 32'h0000_0300 + 32'(4 * i), r, 1'b0, 2'd0,
                   32'h0, E_NONE, stalls);
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            r    = $random(seed);
            op   = mem_op_e'({1'b0, r[2:0]} + 4'd1);
            addr = 32'h0000_0300 + {26'd0, r[11:8], 2'b00};
            case (op)
                LD_B, LD_BU, ST_B: addr[1:0] = r[13:12];
                LD_H, LD_HU, ST_H: addr[1:0] = {r[13], 1'b0};
                default: begin
                end
            endcase
            r = $random(seed);
            run_op(16'hFFFF, op, addr, r, 1'b0, 2'd0, model_load(op, addr[9:0]),
                   E_NONE, stalls);
        end
        drain();
        $display("random phase: %0d ops, %0d loads checked", RAND_OPS, rand_loads);

        $display("Checked %0d writebacks, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_subsys_top.f
logic/mem_pkg.sv
logic/core_pkg.sv
logic/tlb_lookup.sv
logic/mem1_stage.sv
logic/mem2_stage.sv
logic/data_ram.sv
logic/mem_subsys_top.sv
test/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -f mem_subsys_top.f \
    --top-module tb_mem_subsys -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log
grep -q "All tests passed" sim.log
